// File: Bender.yml
package:
  name: bilinear_demosaic

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/demosaic_pkg.sv
      - logic/stream_sideband_pipe.sv
      - logic/demosaic_lane.sv
      - logic/bilinear_demosaic.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/demosaic_tb.sv

// File: logic/bilinear_demosaic.sv
// Bilinear demosaic top
// Cuts the three-row raw window into one 3x3 neighbourhood per lane and
// returns four RGB pixels per beat, three cycles after the strobe

`include "demosaic_settings.svh"

module bilinear_demosaic #(
    parameter demosaic_pkg::bayer_order_e BAYER_ORDER = demosaic_pkg::BGGR
) (
    input  logic                      I_clk,
    input  logic                      I_rst_n,
    input  logic                      in_valid,
    input  demosaic_pkg::sideband_t   in_side,
    input  logic                      row_odd,
    input  demosaic_pkg::raw_window_t in_window,
    output logic                      out_valid,
    output demosaic_pkg::sideband_t   out_side,
    output demosaic_pkg::rgb_beat_t   out_beat
);

    localparam int LANES = `DEMOSAIC_LANES;

    // Lane k is centred on window column 4+k
    localparam int FIRST_COL = 3;

    demosaic_pkg::stage_en_t  stage_en;
    demosaic_pkg::rgb_pixel_t lane_px [LANES];

    // ----------------------------------------
    // Beat timing
    // ----------------------------------------
    stream_sideband_pipe sideband_pipe_i (
        .I_clk     (I_clk),
        .I_rst_n   (I_rst_n),
        .in_valid  (in_valid),
        .in_side   (in_side),
        .stage_en  (stage_en),
        .out_valid (out_valid),
        .out_side  (out_side)
    );

    // ----------------------------------------
    // Lanes
    // ----------------------------------------
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        demosaic_pkg::nbhd_t nbhd;

        assign nbhd = '{top: in_window.last_row[FIRST_COL+k +: 3],
                        mid: in_window.cur_row[FIRST_COL+k +: 3],
                        bot: in_window.next_row[FIRST_COL+k +: 3]};

        demosaic_lane #(
            .LANE_ODD    ((k % 2) == 1),
            .BAYER_ORDER (BAYER_ORDER)
        ) lane_i (
            .I_clk    (I_clk),
            .I_rst_n  (I_rst_n),
            .stage_en (stage_en),
            .row_odd  (row_odd),
            .nbhd     (nbhd),
            .pixel    (lane_px[k])
        );
    end

    // Lane 0 into the low word
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            out_beat.px[k] = lane_px[k];
        end
    end

endmodule

// File: logic/demosaic_lane.sv
// Demosaic lane
// Bilinear interpolation of one output pixel in three stages:
// pair sums, totals, then division by shift

`include "demosaic_settings.svh"

module demosaic_lane #(
    parameter bit                         LANE_ODD    = 1'b0,
    parameter demosaic_pkg::bayer_order_e BAYER_ORDER = demosaic_pkg::BGGR
) (
    input  logic                     I_clk,
    input  logic                     I_rst_n,
    input  demosaic_pkg::stage_en_t  stage_en,
    input  logic                     row_odd,
    input  demosaic_pkg::nbhd_t      nbhd,
    output demosaic_pkg::rgb_pixel_t pixel
);

    localparam int PIX_W  = `DEMOSAIC_PIX_W;
    localparam int PAIR_W = `DEMOSAIC_PIX_W + 1;
    localparam int SUM_W  = `DEMOSAIC_SUM_W;
    localparam int NUM_CH = 3;
    localparam int CH_R   = 2;
    localparam int CH_G   = 1;
    localparam int CH_B   = 0;

    // Largest legal total, four full-scale pixels
    localparam logic [SUM_W-1:0] SUM_LIMIT = SUM_W'(4 * ((1 << PIX_W) - 1));

    // Two pair sums and the divide shift of one channel
    typedef struct packed {
        logic [PAIR_W-1:0] part0;
        logic [PAIR_W-1:0] part1;
        logic [1:0]        shift;
    } pair_t;

    typedef struct packed {
        logic [SUM_W-1:0] sum;
        logic [1:0]       shift;
    } total_t;

    demosaic_pkg::site_e site;
    pair_t [NUM_CH-1:0]  pair_d;
    pair_t [NUM_CH-1:0]  pair_q;
    total_t [NUM_CH-1:0] tot_q;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Colour at (0,0) from the order, then flip by row and column parity
    function automatic demosaic_pkg::site_e site_of(input logic r_odd, input logic c_odd);
        demosaic_pkg::site_e base;
        unique case (BAYER_ORDER)
            demosaic_pkg::BGGR: base = demosaic_pkg::SITE_B;
            demosaic_pkg::RGGB: base = demosaic_pkg::SITE_R;
            demosaic_pkg::GBRG: base = demosaic_pkg::SITE_GB;
            demosaic_pkg::GRBG: base = demosaic_pkg::SITE_GR;
        endcase
        return demosaic_pkg::site_e'(base ^ {r_odd, c_odd});
    endfunction

    function automatic logic [PAIR_W-1:0] add2(input logic [PIX_W-1:0] a,
                                               input logic [PIX_W-1:0] b);
        return {1'b0, a} + {1'b0, b};
    endfunction

    // Own colour, taken as is
    function automatic pair_t pass_own(input logic [PIX_W-1:0] c);
        pair_t p;
        p       = '0;
        p.part0 = {1'b0, c};
        return p;
    endfunction

    // Mean of two neighbours
    function automatic pair_t half(input logic [PIX_W-1:0] a,
                                   input logic [PIX_W-1:0] b);
        pair_t p;
        p       = '0;
        p.part0 = add2(a, b);
        p.shift = 2'd1;
        return p;
    endfunction

    // Mean of four neighbours
    function automatic pair_t quad(input logic [PIX_W-1:0] a, input logic [PIX_W-1:0] b,
                                   input logic [PIX_W-1:0] c, input logic [PIX_W-1:0] d);
        pair_t p;
        p.part0 = add2(a, b);
        p.part1 = add2(c, d);
        p.shift = 2'd2;
        return p;
    endfunction

    function automatic logic [PIX_W-1:0] scale(input total_t t);
        logic [SUM_W-1:0] shifted;
        shifted = t.sum >> t.shift;
        return shifted[PIX_W-1:0];
    endfunction

    // ----------------------------------------
    // Stage 1, pair sums per channel
    // ----------------------------------------
    assign site = site_of(row_odd, LANE_ODD);

    always_comb begin
        pair_d = '0;
        unique case (site)
            demosaic_pkg::SITE_R: begin
                pair_d[CH_R] = pass_own(nbhd.mid[1]);
                pair_d[CH_G] = quad(nbhd.top[1], nbhd.bot[1], nbhd.mid[0], nbhd.mid[2]);
                pair_d[CH_B] = quad(nbhd.top[0], nbhd.top[2], nbhd.bot[0], nbhd.bot[2]);
            end
            demosaic_pkg::SITE_B: begin
                pair_d[CH_B] = pass_own(nbhd.mid[1]);
                pair_d[CH_G] = quad(nbhd.top[1], nbhd.bot[1], nbhd.mid[0], nbhd.mid[2]);
                pair_d[CH_R] = quad(nbhd.top[0], nbhd.top[2], nbhd.bot[0], nbhd.bot[2]);
            end
            // Green in a red row, red left/right and blue above/below
            demosaic_pkg::SITE_GR: begin
                pair_d[CH_G] = pass_own(nbhd.mid[1]);
                pair_d[CH_R] = half(nbhd.mid[0], nbhd.mid[2]);
                pair_d[CH_B] = half(nbhd.top[1], nbhd.bot[1]);
            end
            demosaic_pkg::SITE_GB: begin
                pair_d[CH_G] = pass_own(nbhd.mid[1]);
                pair_d[CH_B] = half(nbhd.mid[0], nbhd.mid[2]);
                pair_d[CH_R] = half(nbhd.top[1], nbhd.bot[1]);
            end
        endcase
    end

    always_ff @(posedge I_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            pair_q <= '0;
        end else if (stage_en[0]) begin
            pair_q <= pair_d;
        end
    end

    // ----------------------------------------
    // Stage 2, totals
    // ----------------------------------------
    always_ff @(posedge I_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            tot_q <= '0;
        end else if (stage_en[1]) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                tot_q[ch].sum   <= SUM_W'(pair_q[ch].part0) + SUM_W'(pair_q[ch].part1);
                tot_q[ch].shift <= pair_q[ch].shift;
            end
        end
    end

    // ----------------------------------------
    // Stage 3, divide and pack
    // ----------------------------------------
    always_ff @(posedge I_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            pixel <= '0;
        end else if (stage_en[2]) begin
            pixel <= '{pad:   '0,
                       red:   scale(tot_q[CH_R]),
                       green: scale(tot_q[CH_G]),
                       blue:  scale(tot_q[CH_B])};
        end
    end

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_chk
        // Shift code from stage 1 is a real divisor when stage 2 takes it
        a_shift_code: assert property (@(posedge I_clk) disable iff (!I_rst_n)
            stage_en[1] |-> pair_q[ch].shift != 2'd3);

        a_total_range: assert property (@(posedge I_clk) disable iff (!I_rst_n)
            stage_en[2] |-> tot_q[ch].sum <= SUM_LIMIT);
    end

endmodule

// File: logic/demosaic_pkg.sv
// Demosaic package
// Bayer order, site colour and the packed stream types

`include "demosaic_settings.svh"

package demosaic_pkg;

    // Letters 1-2 give the even row, letters 3-4 the odd row
    typedef enum logic [1:0] {
        BGGR = 2'd0,
        RGGB = 2'd1,
        GBRG = 2'd2,
        GRBG = 2'd3
    } bayer_order_e;

    // Bit 0 flips with column parity, bit 1 with row parity
    typedef enum logic [1:0] {
        SITE_R  = 2'd0,
        SITE_GR = 2'd1,
        SITE_GB = 2'd2,
        SITE_B  = 2'd3
    } site_e;

    // Three window rows, column 0 in the top byte
    typedef struct packed {
        logic [0:`DEMOSAIC_WIN_COLS-1][`DEMOSAIC_PIX_W-1:0] last_row;
        logic [0:`DEMOSAIC_WIN_COLS-1][`DEMOSAIC_PIX_W-1:0] cur_row;
        logic [0:`DEMOSAIC_WIN_COLS-1][`DEMOSAIC_PIX_W-1:0] next_row;
    } raw_window_t;

    // 3x3 block around one centre pixel
    typedef struct packed {
        logic [0:2][`DEMOSAIC_PIX_W-1:0] top;
        logic [0:2][`DEMOSAIC_PIX_W-1:0] mid;
        logic [0:2][`DEMOSAIC_PIX_W-1:0] bot;
    } nbhd_t;

    typedef struct packed {
        logic [`DEMOSAIC_PIX_W-1:0] pad;
        logic [`DEMOSAIC_PIX_W-1:0] red;
        logic [`DEMOSAIC_PIX_W-1:0] green;
        logic [`DEMOSAIC_PIX_W-1:0] blue;
    } rgb_pixel_t;

    // Lane 0 sits in the low word
    typedef struct packed {
        rgb_pixel_t [`DEMOSAIC_LANES-1:0] px;
    } rgb_beat_t;

    // Frame start and line end
    typedef struct packed {
        logic user;
        logic last;
    } sideband_t;

    typedef logic [`DEMOSAIC_DEPTH-1:0] stage_en_t;

endpackage

// File: logic/demosaic_settings.svh
// Demosaic settings
// Pixel widths, lane count, window size and pipeline depth shared by
// the bilinear demosaic block

`ifndef DEMOSAIC_SETTINGS_SVH
`define DEMOSAIC_SETTINGS_SVH

// Raw pixel and colour channel width
`define DEMOSAIC_PIX_W 8

// Output pixels per beat
`define DEMOSAIC_LANES 4

// Raw pixels per window row
`define DEMOSAIC_WIN_COLS 12

// Sum of up to four pixels
`define DEMOSAIC_SUM_W 10

// Cycles from input strobe to output strobe
`define DEMOSAIC_DEPTH 3

`endif

// File: logic/stream_sideband_pipe.sv
// Stream sideband pipe
// Delays valid, frame start and line end by the pipeline depth and
// hands out the per-stage enables taken from the same valid history

`include "demosaic_settings.svh"

module stream_sideband_pipe (
    input  logic                    I_clk,
    input  logic                    I_rst_n,
    input  logic                    in_valid,
    input  demosaic_pkg::sideband_t in_side,
    output demosaic_pkg::stage_en_t stage_en,
    output logic                    out_valid,
    output demosaic_pkg::sideband_t out_side
);

    localparam int DEPTH = `DEMOSAIC_DEPTH;

    logic [DEPTH-1:0]                    valid_q;
    demosaic_pkg::sideband_t [DEPTH-1:0] side_q;

    // ----------------------------------------
    // Delay line
    // ----------------------------------------
    always_ff @(posedge I_clk or negedge I_rst_n) begin
        if (!I_rst_n) begin
            valid_q <= '0;
            side_q  <= '0;
        end else begin
            valid_q <= {valid_q[DEPTH-2:0], in_valid};
            // Sideband only counts with a strobe
            side_q[0] <= in_valid ? in_side : '0;
            for (int i = 1; i < DEPTH; i++) begin
                side_q[i] <= side_q[i-1];
            end
        end
    end

    // Stage k runs when the beat entered k cycles ago
    assign stage_en  = {valid_q[DEPTH-2:0], in_valid};

    assign out_valid = valid_q[DEPTH-1];
    assign out_side  = side_q[DEPTH-1];

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_side_idle: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        !out_valid |-> out_side == '0);

    a_valid_lat: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        in_valid |-> ##DEPTH out_valid);

    // No output strobe without a strobe DEPTH cycles earlier
    a_valid_src: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        out_valid |-> $past(in_valid, DEPTH));

endmodule

// File: project.f
+incdir+logic
logic/demosaic_pkg.sv
logic/stream_sideband_pipe.sv
logic/demosaic_lane.sv
logic/bilinear_demosaic.sv
testbench/demosaic_tb.sv

// File: testbench/demosaic_tb.sv
// Bilinear demosaic testbench
// Drives raw Bayer windows into the demosaic top level and checks each
// output beat against a reference model of the interpolation rule

`include "demosaic_settings.svh"

module demosaic_tb #(
    // Override per run to cover the other Bayer orders
    parameter demosaic_pkg::bayer_order_e BAYER_ORDER = demosaic_pkg::BGGR
);

    localparam int LANES      = `DEMOSAIC_LANES;
    localparam int DEPTH      = `DEMOSAIC_DEPTH;
    localparam int COLS       = `DEMOSAIC_WIN_COLS;
    // About 35 beats and their gaps take under 100 cycles
    localparam int MAX_CYCLES = 600;

    typedef struct packed {
        demosaic_pkg::rgb_beat_t beat;
        demosaic_pkg::sideband_t side;
        logic [7:0]              tid;
    } expect_t;

    logic                      I_clk;
    logic                      I_rst_n;
    logic                      in_valid;
    demosaic_pkg::sideband_t   in_side;
    logic                      row_odd;
    demosaic_pkg::raw_window_t in_window;
    logic                      out_valid;
    demosaic_pkg::sideband_t   out_side;
    demosaic_pkg::rgb_beat_t   out_beat;

    expect_t exp_q[$];
    expect_t exp_head = '0;
    int      exp_count = 0;
    logic    started = 1'b0;
    int      error_count = 0;
    int      beats_checked = 0;
    int      cycle_count = 0;

    bilinear_demosaic #(
        .BAYER_ORDER (BAYER_ORDER)
    ) bilinear_demosaic_i (
        .I_clk     (I_clk),
        .I_rst_n   (I_rst_n),
        .in_valid  (in_valid),
        .in_side   (in_side),
        .row_odd   (row_odd),
        .in_window (in_window),
        .out_valid (out_valid),
        .out_side  (out_side),
        .out_beat  (out_beat)
    );

    initial begin
        I_clk = 1'b0;
        forever #5 I_clk = ~I_clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic string test_name(input logic [7:0] tid);
        case (tid)
            8'd1:    return "flat_field";
            8'd2:    return "random_sites";
            8'd3:    return "sideband_latency";
            8'd4:    return "back_to_back";
            default: return "none";
        endcase
    endfunction

    function automatic string order_name(input demosaic_pkg::bayer_order_e order);
        case (order)
            demosaic_pkg::BGGR: return "BGGR";
            demosaic_pkg::RGGB: return "RGGB";
            demosaic_pkg::GBRG: return "GBRG";
            default:            return "GRBG";
        endcase
    endfunction

    function automatic demosaic_pkg::rgb_pixel_t ref_pixel(
        input demosaic_pkg::raw_window_t w, input logic r_odd, input int k);
        demosaic_pkg::rgb_pixel_t p;
        string name;
        byte   letter;
        bit    red_row;
        int    c, up, dn, lf, rt, edges, corners, horiz, vert;
        name    = order_name(BAYER_ORDER);
        letter  = name[2 * r_odd + (k % 2)];
        red_row = (name[2 * r_odd] == "R") || (name[2 * r_odd + 1] == "R");
        c       = w.cur_row[4+k];
        lf      = w.cur_row[3+k];
        rt      = w.cur_row[5+k];
        up      = w.last_row[4+k];
        dn      = w.next_row[4+k];
        edges   = (up + dn + lf + rt) / 4;
        corners = (w.last_row[3+k] + w.last_row[5+k] + w.next_row[3+k]
                   + w.next_row[5+k]) / 4;
        horiz   = (lf + rt) / 2;
        vert    = (up + dn) / 2;
        p       = '0;
        if (letter == "R") begin
            p.red   = c;
            p.green = edges;
            p.blue  = corners;
        end else if (letter == "B") begin
            p.blue  = c;
            p.green = edges;
            p.red   = corners;
        end else begin
            p.green = c;
            // Colour of the row comes from left and right
            p.red   = red_row ? horiz : vert;
            p.blue  = red_row ? vert : horiz;
        end
        return p;
    endfunction

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic demosaic_pkg::raw_window_t random_window();
        demosaic_pkg::raw_window_t w;
        for (int col = 0; col < COLS; col++) begin
            w.last_row[col] = 8'($urandom);
            w.cur_row[col]  = 8'($urandom);
            w.next_row[col] = 8'($urandom);
        end
        return w;
    endfunction

    function automatic demosaic_pkg::raw_window_t flat_window(input logic [7:0] v);
        demosaic_pkg::raw_window_t w;
        for (int col = 0; col < COLS; col++) begin
            w.last_row[col] = v;
            w.cur_row[col]  = v;
            w.next_row[col] = v;
        end
        return w;
    endfunction

    task automatic update_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : '0;
    endtask

    // Called a time unit after a rising edge, returns at the same phase
    task automatic send_beat(input demosaic_pkg::raw_window_t w, input logic r_odd,
                             input demosaic_pkg::sideband_t side, input int tid);
        expect_t e;
        for (int k = 0; k < LANES; k++) begin
            e.beat.px[k] = ref_pixel(w, r_odd, k);
        end
        e.side    = side;
        e.tid     = 8'(tid);
        started   = 1'b1;
        in_valid  = 1'b1;
        in_window = w;
        row_odd   = r_odd;
        in_side   = side;
        exp_q.push_back(e);
        update_head();
        @(posedge I_clk);
        #1;
        in_valid = 1'b0;
        in_side  = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            // Junk between strobes, the DUT must ignore it
            in_window = random_window();
            in_side   = 2'($urandom);
            row_odd   = 1'($urandom);
            @(posedge I_clk);
            #1;
        end
    endtask

    // Retire the head once the sampled strobe has been checked
    always @(posedge I_clk) begin
        if (I_rst_n && out_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            beats_checked++;
            update_head();
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_idle: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        !started |-> (!out_valid && out_side == '0 && out_beat == '0))
        else begin
            error_count++;
            $display("CHECK FAILED reset_idle expected 0 actual beat %h side %b",
                     $sampled(out_beat), $sampled(out_side));
        end

    a_side_idle: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        !out_valid |-> out_side == '0)
        else begin
            error_count++;
            $display("CHECK FAILED side_idle expected 00 actual %b", $sampled(out_side));
        end

    a_beat: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        out_valid |-> out_beat == exp_head.beat)
        else begin
            error_count++;
            $display("CHECK FAILED %s beat expected %h actual %h",
                     test_name($sampled(exp_head.tid)), $sampled(exp_head.beat),
                     $sampled(out_beat));
        end

    a_side: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        out_valid |-> out_side == exp_head.side)
        else begin
            error_count++;
            $display("CHECK FAILED %s side expected %b actual %b",
                     test_name($sampled(exp_head.tid)), $sampled(exp_head.side),
                     $sampled(out_side));
        end

    a_expected: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        out_valid |-> exp_count > 0)
        else begin
            error_count++;
            $display("Output beat appeared while no beat was expected");
        end

    a_latency: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        in_valid |-> ##DEPTH out_valid)
        else begin
            error_count++;
            $display("A beat did not leave %0d cycles after its strobe", DEPTH);
        end

    a_no_extra: assert property (@(posedge I_clk) disable iff (!I_rst_n)
        out_valid |-> $past(in_valid, DEPTH))
        else begin
            error_count++;
            $display("Output strobe without an input strobe %0d cycles before", DEPTH);
        end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h6662_414e));
        I_rst_n   = 1'b0;
        in_valid  = 1'b0;
        in_side   = '0;
        row_odd   = 1'b0;
        in_window = '0;
        repeat (5) @(posedge I_clk);
        #1;
        I_rst_n = 1'b1;
        idle_cycles(6);

        // Flat field on both row parities
        send_beat(flat_window(8'h00), 1'b0, '0, 1);
        send_beat(flat_window(8'hff), 1'b1, '0, 1);
        idle_cycles(2);
        send_beat(flat_window(8'h5a), 1'b1, '0, 1);
        send_beat(flat_window(8'h81), 1'b0, '0, 1);
        idle_cycles(4);

        for (int i = 0; i < 16; i++) begin
            send_beat(random_window(), 1'(i % 2), '0, 2);
            idle_cycles(i % 3);
        end
        idle_cycles(4);

        // Frame start, then a later line end
        send_beat(random_window(), 1'b0, '{user: 1'b1, last: 1'b0}, 3);
        idle_cycles(3);
        send_beat(random_window(), 1'b1, '{user: 1'b0, last: 1'b1}, 3);
        idle_cycles(5);

        for (int i = 0; i < 8; i++) begin
            send_beat(random_window(), 1'($urandom), '{user: (i == 0), last: (i == 7)}, 4);
        end
        idle_cycles(1);
        send_beat(random_window(), 1'b0, '0, 4);
        send_beat(random_window(), 1'b1, '0, 4);
        idle_cycles(3);
        send_beat(random_window(), 1'b1, '0, 4);

        wait (exp_count == 0);
        idle_cycles(4);
        $display("Run done: %0d beats checked, %0d errors", beats_checked, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge I_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d beats still outstanding",
                 MAX_CYCLES, exp_count);
        $display("Run stopped: %0d beats checked, %0d errors", beats_checked, error_count);
        $display("Simulation failed");
        $finish;
    end

endmodule
